//--- sifh.f
sifhPkg.sv
histRam.sv
peakFinder.sv
histCtrl.sv
sifhRegs.sv
sifhTop.sv
sifhTb.sv

//--- runSim.sh
#!/bin/sh
# build the sifh testbench with Verilator, run it, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sifhTb \
    -f sifh.f -o sifhSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sifhSim > sim.log 2>&1 || true
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

//--- sifhTb.sv
`timescale 1ns/1ps

module sifhTb;

    // room for three frames of up to 700 samples plus clear, scan and readout
    localparam int timeoutCycles = 30000;

    logic clk, res;
    logic [sifhPkg::axiAddrBits-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic sampleValid, sampleReady;
    logic [sifhPkg::pixelBits-1:0] samplePixel;
    logic [sifhPkg::sampleBits-1:0] sampleTime;

    integer seed;
    int cycles = 0;
    int model [sifhPkg::ramDepth];    // reference counts in the same {pixel, bin} layout
    logic [31:0] rdWord;

    sifhTop u_sifhTop (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("ERR %s expected %h actual %h", name, expVal, actVal);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;    // inputs change just after the edge
    endtask

    task automatic axiWrite(input logic [sifhPkg::axiAddrBits-1:0] addr, input logic [31:0] data);
        int delay;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do begin
            nextCycle();
        end while (!awready);
        checkVal("wready", 32'h1, 32'(wready));    // both ready lines pulse together
        nextCycle();    // transfer happens on this edge
        awvalid = 1'b0;
        wvalid = 1'b0;
        checkVal("wready", 32'h0, 32'(wready));
        while (!bvalid) begin
            nextCycle();
        end
        delay = {$random(seed)} % 4;
        repeat (delay) begin
            nextCycle();
            checkVal("bvalid", 32'h1, 32'(bvalid));    // must wait for bready
        end
        checkVal("bresp", 32'h0, 32'(bresp));
        bready = 1'b1;
        nextCycle();
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [sifhPkg::axiAddrBits-1:0] addr, output logic [31:0] data);
        int delay;
        araddr = addr;
        arvalid = 1'b1;
        do begin
            nextCycle();
        end while (!arready);
        nextCycle();
        arvalid = 1'b0;
        while (!rvalid) begin
            nextCycle();    // histogram words take a detour through the controller
        end
        data = rdata;
        checkVal("rresp", 32'h0, 32'(rresp));
        delay = {$random(seed)} % 4;
        repeat (delay) begin
            nextCycle();
            checkVal("rvalid", 32'h1, 32'(rvalid));
            checkVal("rdata", data, rdata);
        end
        rready = 1'b1;
        nextCycle();
        rready = 1'b0;
    endtask

    task automatic sendSample(input logic [sifhPkg::pixelBits-1:0] pix,
                              input logic [sifhPkg::sampleBits-1:0] stamp);
        int addr;
        samplePixel = pix;
        sampleTime = stamp;
        sampleValid = 1'b1;
        while (!sampleReady) begin
            nextCycle();
        end
        nextCycle();
        sampleValid = 1'b0;
        addr = {pix, stamp[sifhPkg::sampleBits-1 -: sifhPkg::binBits]};
        if (model[addr] < 32'hffff) begin
            model[addr] = model[addr] + 1;    // saturating count
        end
    endtask

    task automatic runFrame(input int len, input bit busyPoke);
        logic [sifhPkg::pixelBits-1:0] pix;
        logic [sifhPkg::binBits-1:0] bin;
        int gap;
        for (int a = 0; a < sifhPkg::ramDepth; a++) begin
            model[a] = 0;
        end
        axiWrite(sifhPkg::regFrameLen, 32'(len));
        axiWrite(sifhPkg::regCtrl, 32'h1);
        pix = '0;
        bin = '0;
        for (int i = 0; i < len; i++) begin
            if (busyPoke && i == len / 2) begin
                axiRead(sifhPkg::regStatus, rdWord);
                checkVal("status", 32'h2, rdWord);
                axiWrite(sifhPkg::regCtrl, 32'h1);    // start while busy is ignored
            end
            // half the samples repeat the last bin to exercise forwarding
            if (i == 0 || {$random(seed)} % 2 == 0) begin
                pix = 2'($random(seed));
                case ({$random(seed)} % 4)
                    0: bin = 6'd5;
                    1: bin = 6'd6;
                    2: bin = 6'd40;
                    default: bin = 6'($random(seed));
                endcase
            end
            sendSample(pix, {bin, 6'($random(seed))});
            gap = ({$random(seed)} % 2 == 0) ? 0 : 1 + {$random(seed)} % 3;
            repeat (gap) begin
                nextCycle();
            end
        end
        do begin
            axiRead(sifhPkg::regStatus, rdWord);
        end while (rdWord[0] !== 1'b1);
        checkVal("status", 32'h1, rdWord);
    endtask

    task automatic checkHist();
        for (int a = 0; a < sifhPkg::ramDepth; a++) begin
            axiRead(sifhPkg::regHistBase + 11'(4 * a), rdWord);
            checkVal($sformatf("hist[%0d]", a), 32'(model[a]), rdWord);
        end
    endtask

    task automatic checkPeaks();
        int best;
        int bestBin;
        for (int p = 0; p < sifhPkg::pixelNum; p++) begin
            best = 0;
            bestBin = 0;
            for (int b = 0; b < sifhPkg::binNum; b++) begin
                if (model[p * sifhPkg::binNum + b] > best) begin    // lowest bin wins a tie
                    best = model[p * sifhPkg::binNum + b];
                    bestBin = b;
                end
            end
            axiRead(sifhPkg::regPeakBase + 11'(4 * p), rdWord);
            checkVal($sformatf("peak[%0d]", p), {16'(best), 16'(bestBin)}, rdWord);
        end
    endtask

    initial begin
        seed = 32'hc794;
        res = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleTime = '0;
        for (int a = 0; a < sifhPkg::ramDepth; a++) begin
            model[a] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        nextCycle();

        axiRead(sifhPkg::regStatus, rdWord);
        checkVal("status", 32'h0, rdWord);
        checkPeaks();

        runFrame(300 + {$random(seed)} % 401, 1'b0);
        checkHist();
        checkPeaks();

        // second frame must start from cleared bins
        runFrame(300 + {$random(seed)} % 401, 1'b1);
        checkHist();
        checkPeaks();

        runFrame(0, 1'b0);
        checkHist();
        checkPeaks();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic                               clk,
    input  logic                               res,
    input  logic [sifhPkg::axiAddrBits-1:0]    awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [31:0]                        wdata,
    input  logic [3:0]                         wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [sifhPkg::axiAddrBits-1:0]    araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [31:0]                        rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,
    input  logic                               sampleValid,
    input  logic [sifhPkg::pixelBits-1:0]      samplePixel,
    input  logic [sifhPkg::sampleBits-1:0]     sampleTime,
    output logic                               sampleReady
);

    // register block to controller
    logic start, busy, done, histRdReq, histRdAck;
    logic [sifhPkg::frameLenBits-1:0] frameLen;
    logic [sifhPkg::ramAddrBits-1:0] histRdAddr;
    logic [sifhPkg::countBits-1:0] histRdData;

    // RAM ports
    logic wrEn, rdEn;
    logic [sifhPkg::ramAddrBits-1:0] wrAddr, rdAddr;
    logic [sifhPkg::countBits-1:0] wrData, rdData;

    // peak scan
    logic scanClear, scanValid;
    logic [sifhPkg::ramAddrBits-1:0] scanAddr;
    logic [sifhPkg::countBits-1:0] scanCount;
    logic [sifhPkg::pixelNum*sifhPkg::binBits-1:0] peakBin;
    logic [sifhPkg::pixelNum*sifhPkg::countBits-1:0] peakCount;

    sifhRegs u_sifhRegs (.*);

    histCtrl u_histCtrl (.*);

    histRam u_histRam (.*);

    peakFinder u_peakFinder (.*);

endmodule

//--- sifhRegs.sv
`timescale 1ns/1ps

module sifhRegs (
    input  logic                                               clk,
    input  logic                                               res,
    input  logic [sifhPkg::axiAddrBits-1:0]                    awaddr,
    input  logic                                               awvalid,
    output logic                                               awready,
    input  logic [31:0]                                        wdata,
    input  logic [3:0]                                         wstrb,
    input  logic                                               wvalid,
    output logic                                               wready,
    output logic [1:0]                                         bresp,
    output logic                                               bvalid,
    input  logic                                               bready,
    input  logic [sifhPkg::axiAddrBits-1:0]                    araddr,
    input  logic                                               arvalid,
    output logic                                               arready,
    output logic [31:0]                                        rdata,
    output logic [1:0]                                         rresp,
    output logic                                               rvalid,
    input  logic                                               rready,
    input  logic                                               busy,
    input  logic                                               done,
    input  logic [sifhPkg::pixelNum*sifhPkg::binBits-1:0]      peakBin,
    input  logic [sifhPkg::pixelNum*sifhPkg::countBits-1:0]    peakCount,
    output logic                                               start,
    output logic [sifhPkg::frameLenBits-1:0]                   frameLen,
    output logic                                               histRdReq,
    output logic [sifhPkg::ramAddrBits-1:0]                    histRdAddr,
    input  logic                                               histRdAck,
    input  logic [sifhPkg::countBits-1:0]                      histRdData
);

    logic histPend;
    logic isHist, isPeak;
    logic [sifhPkg::pixelBits-1:0] peakIdx;
    logic [31:0] regData;

    assign bresp = 2'b00;    // always OKAY
    assign rresp = 2'b00;

    // read decode straight from address bits
    assign isHist = araddr[sifhPkg::axiAddrBits-1];
    assign isPeak = araddr[sifhPkg::axiAddrBits-1:4] == sifhPkg::regPeakBase[sifhPkg::axiAddrBits-1:4];
    assign peakIdx = araddr[2 +: sifhPkg::pixelBits];

    always_comb begin
        regData = '0;
        if (isPeak) begin
            regData[31:16] = peakCount[peakIdx*sifhPkg::countBits +: sifhPkg::countBits];
            regData[sifhPkg::binBits-1:0] = peakBin[peakIdx*sifhPkg::binBits +: sifhPkg::binBits];
        end else if (araddr == sifhPkg::regFrameLen) begin
            regData[sifhPkg::frameLenBits-1:0] = frameLen;
        end else if (araddr == sifhPkg::regStatus) begin
            regData[1:0] = {busy, done};
        end
    end

    // write channel
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            start <= 1'b0;
            frameLen <= '0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;    // one-cycle pulse
            wready <= awvalid && wvalid && !awready && !bvalid;
            start <= 1'b0;
            if (awready) begin
                bvalid <= 1'b1;
                if (awaddr == sifhPkg::regCtrl && wstrb[0]) begin
                    start <= wdata[0];
                end
                if (awaddr == sifhPkg::regFrameLen) begin
                    if (wstrb[0]) frameLen[7:0] <= wdata[7:0];
                    if (wstrb[1]) frameLen[15:8] <= wdata[15:8];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel, histogram words go through the controller
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            histPend <= 1'b0;
            histRdReq <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid && !histPend;
            histRdReq <= 1'b0;
            if (arready) begin
                if (isHist) begin
                    histPend <= 1'b1;
                    histRdReq <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                end
            end else if (histPend && histRdAck) begin
                histPend <= 1'b0;
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= regData;
            histRdAddr <= araddr[2 +: sifhPkg::ramAddrBits];    // word index in the window
        end else if (histPend && histRdAck) begin
            rdata <= {{(32-sifhPkg::countBits){1'b0}}, histRdData};
        end
    end

    assert property (@(posedge clk) disable iff (!res) bvalid && !bready |=> bvalid);
    assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- histCtrl.sv
`timescale 1ns/1ps

module histCtrl (
    input  logic                               clk,
    input  logic                               res,
    input  logic                               start,
    input  logic [sifhPkg::frameLenBits-1:0]   frameLen,
    input  logic                               sampleValid,
    input  logic [sifhPkg::pixelBits-1:0]      samplePixel,
    input  logic [sifhPkg::sampleBits-1:0]     sampleTime,
    output logic                               sampleReady,
    input  logic                               histRdReq,
    input  logic [sifhPkg::ramAddrBits-1:0]    histRdAddr,
    output logic                               histRdAck,
    output logic [sifhPkg::countBits-1:0]      histRdData,
    output logic                               busy,
    output logic                               done,
    output logic                               wrEn,
    output logic [sifhPkg::ramAddrBits-1:0]    wrAddr,
    output logic [sifhPkg::countBits-1:0]      wrData,
    output logic                               rdEn,
    output logic [sifhPkg::ramAddrBits-1:0]    rdAddr,
    input  logic [sifhPkg::countBits-1:0]      rdData,
    output logic                               scanClear,
    output logic                               scanValid,
    output logic [sifhPkg::ramAddrBits-1:0]    scanAddr,
    output logic [sifhPkg::countBits-1:0]      scanCount
);

    sifhPkg::ctrlState_t state, nextState;

    logic [sifhPkg::ramAddrBits:0] cnt;    // clear and scan sweep, msb ends the scan
    logic [sifhPkg::frameLenBits-1:0] acceptCnt;
    logic [sifhPkg::ramAddrBits-1:0] sampleAddr;
    logic accept, lastTake, hostOk, hostPend;
    logic pipeValid, fwdHit;
    logic [sifhPkg::ramAddrBits-1:0] pipeAddr;
    logic [sifhPkg::countBits-1:0] lastData, accumSrc, accumData;

    assign sampleAddr = {samplePixel, sampleTime[sifhPkg::sampleBits-1 -: sifhPkg::binBits]};
    assign sampleReady = (state == sifhPkg::ACCUM) && (acceptCnt < frameLen);
    assign accept = sampleValid && sampleReady;
    assign lastTake = (acceptCnt == frameLen) || (accept && acceptCnt + 1'b1 == frameLen);
    assign hostOk = (state == sifhPkg::IDLE) || (state == sifhPkg::DONE);

    assign busy = !hostOk;
    assign done = (state == sifhPkg::DONE);

    always_comb begin
        nextState = state;
        case (state)
            sifhPkg::IDLE, sifhPkg::DONE: if (start) nextState = sifhPkg::CLEAR;
            sifhPkg::CLEAR: if (cnt[sifhPkg::ramAddrBits-1:0] == '1) nextState = sifhPkg::ACCUM;
            sifhPkg::ACCUM: if (lastTake) nextState = sifhPkg::DRAIN;
            sifhPkg::DRAIN: nextState = sifhPkg::SCAN;
            sifhPkg::SCAN: if (cnt[sifhPkg::ramAddrBits]) nextState = sifhPkg::DONE;
            default: nextState = sifhPkg::IDLE;
        endcase
    end

    // counting pipeline, forwarding the word still being written
    assign accumSrc = fwdHit ? lastData : rdData;
    assign accumData = (accumSrc == '1) ? accumSrc : accumSrc + 1'b1;    // saturate

    assign wrEn = (state == sifhPkg::CLEAR) || pipeValid;
    assign wrAddr = (state == sifhPkg::CLEAR) ? cnt[sifhPkg::ramAddrBits-1:0] : pipeAddr;
    assign wrData = (state == sifhPkg::CLEAR) ? '0 : accumData;

    // one read port shared by samples, scan and host
    always_comb begin
        case (state)
            sifhPkg::ACCUM: rdAddr = sampleAddr;
            sifhPkg::SCAN: rdAddr = cnt[sifhPkg::ramAddrBits-1:0];
            default: rdAddr = histRdAddr;
        endcase
    end
    assign rdEn = accept || (state == sifhPkg::SCAN && !cnt[sifhPkg::ramAddrBits])
        || (histRdReq && hostOk);

    assign histRdAck = hostPend || (histRdReq && !hostOk);    // zero word at once when busy
    assign histRdData = hostPend ? rdData : '0;

    assign scanClear = (state == sifhPkg::DRAIN);
    assign scanCount = rdData;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifhPkg::IDLE;
            cnt <= '0;
            acceptCnt <= '0;
            pipeValid <= 1'b0;
            fwdHit <= 1'b0;
            hostPend <= 1'b0;
            scanValid <= 1'b0;
        end else begin
            state <= nextState;
            if (state == sifhPkg::CLEAR || state == sifhPkg::SCAN) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
            if (state != sifhPkg::ACCUM) begin
                acceptCnt <= '0;
            end else if (accept) begin
                acceptCnt <= acceptCnt + 1'b1;
            end
            pipeValid <= accept;
            fwdHit <= accept && pipeValid && (pipeAddr == sampleAddr);    // same bin back to back
            hostPend <= histRdReq && hostOk;
            scanValid <= (state == sifhPkg::SCAN) && !cnt[sifhPkg::ramAddrBits];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pipeAddr <= sampleAddr;
        end
        if (pipeValid) begin
            lastData <= accumData;
        end
        scanAddr <= cnt[sifhPkg::ramAddrBits-1:0];    // scan data lags its read by one cycle
    end

    assert property (@(posedge clk) disable iff (!res) sampleReady |-> state == sifhPkg::ACCUM);
    assert property (@(posedge clk) disable iff (!res)
        state == sifhPkg::CLEAR |-> wrEn && wrData == '0);
    assert property (@(posedge clk) disable iff (!res) state == sifhPkg::CLEAR |-> !rdEn);

endmodule

//--- peakFinder.sv
`timescale 1ns/1ps

module peakFinder (
    input  logic                                               clk,
    input  logic                                               res,
    input  logic                                               scanClear,
    input  logic                                               scanValid,
    input  logic [sifhPkg::ramAddrBits-1:0]                    scanAddr,
    input  logic [sifhPkg::countBits-1:0]                      scanCount,
    output logic [sifhPkg::pixelNum*sifhPkg::binBits-1:0]      peakBin,
    output logic [sifhPkg::pixelNum*sifhPkg::countBits-1:0]    peakCount
);

    logic [sifhPkg::countBits-1:0] maxCount [sifhPkg::pixelNum];
    logic [sifhPkg::binBits-1:0] maxBin [sifhPkg::pixelNum];
    logic [sifhPkg::pixelBits-1:0] scanPixel;
    logic [sifhPkg::binBits-1:0] scanBin;

    assign scanPixel = scanAddr[sifhPkg::ramAddrBits-1:sifhPkg::binBits];
    assign scanBin = scanAddr[sifhPkg::binBits-1:0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::pixelNum; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
        end else if (scanClear) begin
            for (int i = 0; i < sifhPkg::pixelNum; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
        end else if (scanValid && scanCount > maxCount[scanPixel]) begin
            // strictly greater, so a tie keeps the earlier bin
            maxCount[scanPixel] <= scanCount;
            maxBin[scanPixel] <= scanBin;
        end
    end

    // flatten for the register block, pixel 0 in the low slice
    for (genvar p = 0; p < sifhPkg::pixelNum; p++) begin : genFlat
        assign peakBin[p*sifhPkg::binBits +: sifhPkg::binBits] = maxBin[p];
        assign peakCount[p*sifhPkg::countBits +: sifhPkg::countBits] = maxCount[p];
    end

endmodule

//--- histRam.sv
`timescale 1ns/1ps

module histRam (
    input  logic                             clk,
    input  logic                             wrEn,
    input  logic [sifhPkg::ramAddrBits-1:0]  wrAddr,
    input  logic [sifhPkg::countBits-1:0]    wrData,
    input  logic                             rdEn,
    input  logic [sifhPkg::ramAddrBits-1:0]  rdAddr,
    output logic [sifhPkg::countBits-1:0]    rdData
);

    logic [sifhPkg::countBits-1:0] mem [0:sifhPkg::ramDepth-1];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        if (rdEn) begin
            // write-first on a collision
            if (wrEn && wrAddr == rdAddr) begin
                rdData <= wrData;
            end else begin
                rdData <= mem[rdAddr];
            end
        end
    end

endmodule

//--- sifhPkg.sv
package sifhPkg;

    // pixel and timestamp geometry
    localparam int pixelBits = 2;
    localparam int pixelNum = 1 << pixelBits;
    localparam int sampleBits = 12;
    localparam int binBits = 6;    // top bits of the timestamp
    localparam int binNum = 1 << binBits;

    // histogram memory, addressed as {pixel, bin}
    localparam int ramAddrBits = pixelBits + binBits;
    localparam int ramDepth = 1 << ramAddrBits;
    localparam int countBits = 16;    // saturating
    localparam int frameLenBits = 16;

    // host register map, byte offsets
    localparam int axiAddrBits = 11;
    localparam logic [axiAddrBits-1:0] regCtrl = 11'h000;
    localparam logic [axiAddrBits-1:0] regFrameLen = 11'h004;
    localparam logic [axiAddrBits-1:0] regStatus = 11'h008;
    localparam logic [axiAddrBits-1:0] regPeakBase = 11'h010;    // one word per pixel
    localparam logic [axiAddrBits-1:0] regHistBase = 11'h400;    // one word per RAM entry

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,    // zero every RAM entry
        ACCUM,    // count incoming samples
        DRAIN,    // last write of the pipeline
        SCAN,     // sweep RAM into the peak finder
        DONE
    } ctrlState_t;

endpackage
